// File: soundCh3.f
source/apuRegPkg.sv
source/apuWavePkg.sv
source/apuTickGen.sv
source/apuRegFile.sv
source/waveChannel.sv
source/soundCh3Top.sv
dv/soundCh3_sva.sv
dv/tbSoundCh3.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the channel 3 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tbSoundCh3 \
	-Mdir build \
	-f soundCh3.f

./build/VtbSoundCh3 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Testbench reported a failure, see sim.log"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi
echo "Simulation passed"

// File: dv/tbSoundCh3.sv
`timescale 1ns/1ps
`default_nettype none

module tbSoundCh3 import apuRegPkg::*, apuWavePkg::*; ();

	localparam int TimeoutCycles = 400000;  // Twice the length test plus margin
	localparam int StepCycles    = 8;       // 4 waveTicks of 2 cycles at freq 2044
	localparam int FullSteps     = 33;      // All 32 positions and the wrap to 0
	localparam int LengthLimit   = 2 * LengthTickDiv + 2;

	logic   iClock = 1'b0;
	logic   reset;
	axiReq  busReq;
	axiRsp  busRsp;
	sampleT dacOut;
	logic   channelOn;

	int     cycles      = 0;   // Rising edges so far
	int     errors      = 0;
	int     checks      = 0;
	int     testsRun    = 0;
	int     testsFailed = 0;
	int     lastFire;          // Edge that took the last write
	regByte waveImage [WaveRamBytes];  // Expected wave RAM contents

	soundCh3Top dut0 (
		.iClock    (iClock),
		.reset     (reset),
		.busReq    (busReq),
		.busRsp    (busRsp),
		.dacOut    (dacOut),
		.channelOn (channelOn)
	);

	always #2 iClock = ~iClock;  // 4 ns period

	// Cycle counter and run limit
	always @(posedge iClock) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("Timeout after %0d cycles, a test stopped making progress", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic checkData(input axiData got, input axiData exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkSample(input sampleT got, input sampleT exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s dacOut %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Outputs are sampled on the falling edge
	task automatic waitForCycle(input int n);
		do
			@(negedge iClock);
		while (cycles < n);
	endtask

	////////////////////////////////////////////////////////////
	// AXI4-Lite master
	////////////////////////////////////////////////////////////
	task automatic axiWrite(input axiAddr addr, input regByte data, input int holdCycles = 0);
		@(posedge iClock);
		busReq.awValid <= 1'b1;
		busReq.awAddr  <= addr;
		busReq.wValid  <= 1'b1;
		busReq.wData   <= axiData'(data);
		do
			@(negedge iClock);
		while (!busRsp.awReady);
		checkFlag(busRsp.wReady, 1'b1, "wReady with awReady");
		lastFire = cycles + 1;  // Next rising edge takes it
		@(posedge iClock);
		busReq.awValid <= 1'b0;
		busReq.wValid  <= 1'b0;
		do
			@(negedge iClock);
		while (!busRsp.bValid);
		repeat (holdCycles) begin
			@(negedge iClock);
			checkFlag(busRsp.bValid, 1'b1, "bValid under back-pressure");
		end
		@(posedge iClock);
		busReq.bReady <= 1'b1;
		@(posedge iClock);
		busReq.bReady <= 1'b0;  // Response taken on this edge
		@(negedge iClock);
		checkFlag(busRsp.bValid, 1'b0, "bValid after bReady");
	endtask

	task automatic axiRead(input axiAddr addr, output axiData data, input int holdCycles = 0);
		@(posedge iClock);
		busReq.arValid <= 1'b1;
		busReq.arAddr  <= addr;
		do
			@(negedge iClock);
		while (!busRsp.arReady);
		@(posedge iClock);
		busReq.arValid <= 1'b0;
		do
			@(negedge iClock);
		while (!busRsp.rValid);
		data = busRsp.rData;
		repeat (holdCycles) begin
			@(negedge iClock);
			checkFlag(busRsp.rValid, 1'b1, "rValid under back-pressure");
			checkData(busRsp.rData, data, "rData under back-pressure");
		end
		@(posedge iClock);
		busReq.rReady <= 1'b1;
		@(posedge iClock);
		busReq.rReady <= 1'b0;
		@(negedge iClock);
		checkFlag(busRsp.rValid, 1'b0, "rValid after rReady");
	endtask

	////////////////////////////////////////////////////////////
	// Playback model and helpers
	////////////////////////////////////////////////////////////
	function automatic sampleT expectedSample(input int pos, input levelT level);
		regByte b;
		sampleT nib;
		b   = waveImage[4'((pos % 32) / 2)];
		nib = (pos % 2 == 0) ? b[7:4] : b[3:0];  // High nibble plays first
		case (level)
			2'd0:    return 4'd0;
			2'd1:    return nib;
			2'd2:    return nib >> 1;
			default: return nib >> 2;
		endcase
	endfunction

	task automatic loadWaveRam();
		regByte val;
		for (int i = 0; i < WaveRamBytes; i++) begin
			val = regByte'($urandom);
			axiWrite(AddrWaveBase + axiAddr'(i), val);
			waveImage[4'(i)] = val;
		end
	endtask

	// Trigger at freq 2044, then check the middle of each step
	task automatic playAndCheck(input levelT level, input int nSteps, input string what);
		int base;
		axiWrite(AddrNr32, regByte'({1'b0, level, 5'b0}));
		axiWrite(AddrNr34, 8'h87);  // Trigger, length off, freq high bits 7
		base = lastFire + 1;        // Edge that resets the position
		for (int k = 0; k < nSteps; k++) begin
			waitForCycle(base + StepCycles * k + 4);
			checkSample(dacOut, expectedSample(k, level), $sformatf("%s step %0d", what, k));
			checkFlag(channelOn, 1'b1, "channelOn while playing");
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testsRun++;
		if (errors == errorsBefore)
			$display("Test %s: ok", name);
		else begin
			testsFailed++;
			$display("Test %s: %0d errors", name, errors - errorsBefore);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic regReadback();
		axiData got;
		axiAddr regAddr [4];
		regByte vals [4];
		regByte nr34Val;
		regAddr = '{AddrNr30, AddrNr31, AddrNr32, AddrNr33};
		axiRead(AddrStatus, got);
		checkData(got, '0, "status before trigger");
		for (int i = 0; i < 4; i++) begin
			vals[2'(i)] = regByte'($urandom);
			axiWrite(regAddr[2'(i)], vals[2'(i)]);
		end
		for (int i = 0; i < 4; i++) begin
			axiRead(regAddr[2'(i)], got);
			checkData(got, axiData'(vals[2'(i)]), $sformatf("NR3%0d readback", i));
		end
		nr34Val = regByte'($urandom) | 8'h80;  // Trigger bit always set
		axiWrite(AddrNr34, nr34Val);
		axiRead(AddrNr34, got);
		checkData(got, axiData'({1'b0, nr34Val[6:0]}), "NR34 readback");
		loadWaveRam();
		for (int i = 0; i < WaveRamBytes; i++) begin
			axiRead(AddrWaveBase + axiAddr'(i), got);
			checkData(got, axiData'(waveImage[4'(i)]), $sformatf("wave RAM byte %0d", i));
		end
	endtask

	task automatic sampleSequence();
		axiWrite(AddrNr30, 8'h80);  // DAC on
		axiWrite(AddrNr33, 8'hFC);  // Freq low byte, 2048 - 2044 = 4
		loadWaveRam();
		playAndCheck(2'd1, FullSteps, "level 1");
	endtask

	task automatic levelScaling();
		playAndCheck(2'd0, FullSteps, "level 0");
		playAndCheck(2'd2, FullSteps, "level 2");
		playAndCheck(2'd3, FullSteps, "level 3");
	endtask

	task automatic lengthExpiry();
		int     fire;
		int     fallEdge;
		axiData got;
		axiWrite(AddrNr31, 8'd254);  // Length count of 2
		axiWrite(AddrNr34, 8'hC7);   // Trigger with length enabled
		fire = lastFire;
		checkFlag(channelOn, 1'b1, "channelOn after trigger");
		axiRead(AddrStatus, got);
		checkData(got, 32'd1, "status while playing");  // Bit 0 follows channelOn
		while (channelOn && cycles <= fire + LengthLimit)
			@(negedge iClock);
		fallEdge = cycles;
		checks++;
		if (channelOn) begin
			errors++;
			$display("Length test: channel still on %0d cycles after the trigger", fallEdge - fire);
		end else if (fallEdge - fire <= LengthTickDiv) begin
			errors++;
			$display("Length test: channel went off early, %0d cycles after the trigger",
				fallEdge - fire);
		end
		checkSample(dacOut, 4'd0, "after length expiry");
		axiRead(AddrStatus, got);
		checkData(got, '0, "status after length expiry");
	endtask

	task automatic dacOffRetrigger();
		axiWrite(AddrNr30, 8'h00);  // DAC off
		axiWrite(AddrNr34, 8'h87);
		waitForCycle(lastFire + 8);
		checkFlag(channelOn, 1'b0, "channelOn with DAC off");
		checkSample(dacOut, 4'd0, "DAC off");
		axiWrite(AddrNr30, 8'h80);
		playAndCheck(2'd1, 12, "before retrigger");
		playAndCheck(2'd1, FullSteps, "after retrigger");  // Mid-wave restart
	endtask

	task automatic backPressure();
		logic [3:0] idx;
		regByte     val;
		axiData     got;
		for (int i = 0; i < 6; i++) begin
			idx = 4'($urandom);
			val = regByte'($urandom);
			axiWrite(AddrWaveBase + axiAddr'(idx), val, $urandom_range(8, 1));
			waveImage[idx] = val;
			axiRead(AddrWaveBase + axiAddr'(idx), got, $urandom_range(8, 1));
			checkData(got, axiData'(val), "wave RAM under back-pressure");
		end
		val = regByte'($urandom);
		axiWrite(AddrNr31, val, $urandom_range(8, 1));
		axiRead(AddrNr31, got, $urandom_range(8, 1));
		checkData(got, axiData'(val), "NR31 under back-pressure");
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////
	initial begin
		int mark;
		void'($urandom(73361));
		busReq <= '0;
		reset  <= 1'b1;
		repeat (2) @(posedge iClock);
		reset <= 1'b0;
		@(posedge iClock);

		mark = errors;
		regReadback();
		reportTest("register readback", mark);
		mark = errors;
		sampleSequence();
		reportTest("sample sequence", mark);
		mark = errors;
		levelScaling();
		reportTest("level scaling", mark);
		mark = errors;
		lengthExpiry();
		reportTest("length expiry", mark);
		mark = errors;
		dacOffRetrigger();
		reportTest("DAC off and retrigger", mark);
		mark = errors;
		backPressure();
		reportTest("back-pressure", mark);

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/soundCh3_sva.sv
`timescale 1ns/1ps
`default_nettype none

module soundCh3_sva import apuRegPkg::*; (
	input wire        iClock,
	input wire        reset,
	input wire axiReq busReq,
	input wire axiRsp busRsp,
	input wire        trigger
);

	// Write response waits for the master
	bValidHold: assert property (@(posedge iClock) disable iff (reset)
		busRsp.bValid && !busReq.bReady |=> busRsp.bValid)
		else $error("bValid dropped before bReady was seen");

	// Read response and its data wait for the master
	rValidHold: assert property (@(posedge iClock) disable iff (reset)
		busRsp.rValid && !busReq.rReady |=> busRsp.rValid)
		else $error("rValid dropped before rReady was seen");

	// Restart pulse is a single cycle
	triggerPulse: assert property (@(posedge iClock) disable iff (reset)
		trigger |=> !trigger)
		else $error("trigger stayed high for two cycles");

endmodule

bind apuRegFile soundCh3_sva sva0 (
	.iClock  (iClock),
	.reset   (reset),
	.busReq  (busReq),
	.busRsp  (busRsp),
	.trigger (trigger)
);

`default_nettype wire

// File: source/soundCh3Top.sv
`timescale 1ns/1ps
`default_nettype none

module soundCh3Top import apuRegPkg::*, apuWavePkg::*; (
	input  wire         iClock,     // 4194304 Hz system clock
	input  wire         reset,
	input  wire  axiReq busReq,
	output axiRsp       busRsp,
	output sampleT      dacOut,
	output logic        channelOn
);

	chanCfg     cfg;
	logic       trigger;
	logic       lengthTick;
	logic       waveTick;
	logic [3:0] waveAddr;
	logic [7:0] waveByte;

	////////////////////////////////////////////////////////////
	// Clock enables
	////////////////////////////////////////////////////////////
	apuTickGen tick0 (
		.iClock     (iClock),
		.reset      (reset),
		.lengthTick (lengthTick),
		.waveTick   (waveTick)
	);

	// CPU registers and wave RAM
	apuRegFile regs0 (
		.iClock    (iClock),
		.reset     (reset),
		.busReq    (busReq),
		.busRsp    (busRsp),
		.cfg       (cfg),
		.trigger   (trigger),
		.waveAddr  (waveAddr),
		.waveByte  (waveByte),
		.channelOn (channelOn)   // Shown in status bit 0
	);

	// Playback engine
	waveChannel chan0 (
		.iClock     (iClock),
		.reset      (reset),
		.cfg        (cfg),
		.trigger    (trigger),
		.waveTick   (waveTick),
		.lengthTick (lengthTick),
		.waveAddr   (waveAddr),
		.waveByte   (waveByte),
		.dacOut     (dacOut),
		.channelOn  (channelOn)
	);

endmodule

`default_nettype wire

// File: source/waveChannel.sv
`timescale 1ns/1ps
`default_nettype none

module waveChannel import apuRegPkg::*, apuWavePkg::*; (
	input  wire          iClock,
	input  wire          reset,
	input  wire  chanCfg cfg,
	input  wire          trigger,     // Restart pulse from NR34
	input  wire          waveTick,    // Timer enable
	input  wire          lengthTick,  // 256 Hz frame enable
	output logic [3:0]   waveAddr,    // Byte index into the wave RAM
	input  wire  [7:0]   waveByte,
	output sampleT       dacOut,
	output logic         channelOn
);

	chanState state;
	chanState nextState;
	freqT     freq;
	levelT    level;
	periodT   freqCnt;      // Counts waveTicks down to the next step
	periodT   periodLoad;
	wavePosT  wavePos;
	lengthT   lengthCnt;
	lengthT   lengthLoad;
	sampleT   nibble;
	sampleT   scaled;
	sampleT   dacReg;
	logic     playing;
	logic     stepDue;
	logic     lengthDone;

	assign freq       = cfg.freq;
	assign level      = cfg.level;
	assign periodLoad = periodT'(FreqPeriodBase) - periodT'(freq);     // 1..2048
	assign lengthLoad = lengthT'(LengthBase) - lengthT'(cfg.lengthLoad); // 1..256

	assign playing    = (state == ChanPlaying);
	assign stepDue    = playing && waveTick && (freqCnt == periodT'(1));
	assign lengthDone = playing && lengthTick && cfg.lengthEnable
		&& (lengthCnt == lengthT'(1));  // Last length tick

	////////////////////////////////////////////////////////////
	// Channel state
	////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		if (trigger) begin
			nextState = cfg.dacOn ? ChanPlaying : ChanOff;  // DAC off blocks start
		end else if (playing && (!cfg.dacOn || lengthDone)) begin
			nextState = ChanOff;
		end
	end

	always_ff @(posedge iClock) begin
		if (reset)
			state <= ChanOff;
		else
			state <= nextState;
	end

	assign channelOn = playing;  // Falls on the same edge as the length expiry

	////////////////////////////////////////////////////////////
	// Frequency timer, position and length counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge iClock) begin
		if (reset) begin
			freqCnt   <= '0;
			wavePos   <= '0;
			lengthCnt <= '0;
		end else if (trigger) begin
			freqCnt   <= periodLoad;  // Restart from index 0
			wavePos   <= '0;
			lengthCnt <= lengthLoad;
		end else begin
			if (stepDue) begin
				freqCnt <= periodLoad;          // Reload with the live frequency
				wavePos <= wavePos + 1'b1;      // Wraps 31 to 0
			end else if (playing && waveTick) begin
				freqCnt <= freqCnt - 1'b1;
			end

			// Length only counts while enabled
			if (playing && lengthTick && cfg.lengthEnable && (lengthCnt != '0))
				lengthCnt <= lengthCnt - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Sample fetch and level shifter
	////////////////////////////////////////////////////////////
	assign waveAddr = wavePos[4:1];                                // Two nibbles per byte
	assign nibble   = wavePos[0] ? waveByte[3:0] : waveByte[7:4];  // High nibble first

	always_comb begin
		case (level)
			2'd0:    scaled = '0;            // Muted
			2'd1:    scaled = nibble;
			2'd2:    scaled = nibble >> 1;
			default: scaled = nibble >> 2;
		endcase
	end

	// One cycle behind the position
	always_ff @(posedge iClock) begin
		if (reset)
			dacReg <= '0;
		else
			dacReg <= playing ? scaled : '0;
	end

	// Silent whenever the channel is off
	assign dacOut = channelOn ? dacReg : '0;

endmodule

`default_nettype wire

// File: source/apuRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module apuRegFile import apuRegPkg::*, apuWavePkg::*; (
	input  wire         iClock,
	input  wire         reset,
	input  wire  axiReq busReq,
	output axiRsp       busRsp,
	output chanCfg      cfg,
	output logic        trigger,    // One cycle after an NR34 write with bit 7
	input  wire  [3:0]  waveAddr,   // From the channel
	output logic [7:0]  waveByte,
	input  wire         channelOn
);

	regByte      nr30;
	regByte      nr31;
	regByte      nr32;
	regByte      nr33;
	logic [6:0]  nr34;               // Trigger bit is not kept
	regByte      waveRam [WaveRamBytes];

	logic        awReadyQ;
	logic        bValidQ;
	logic        arReadyQ;
	logic        rValidQ;
	axiData      rDataQ;
	axiData      readMux;
	logic        writeFire;
	logic        readFire;
	logic        writeWave;
	logic        readWave;

	////////////////////////////////////////////////////////////
	// AXI4-Lite handshake
	////////////////////////////////////////////////////////////
	assign writeFire = awReadyQ && busReq.awValid && busReq.wValid;
	assign readFire  = arReadyQ && busReq.arValid;

	always_ff @(posedge iClock) begin
		if (reset) begin
			awReadyQ <= 1'b0;
			bValidQ  <= 1'b0;
			arReadyQ <= 1'b0;
			rValidQ  <= 1'b0;
			trigger  <= 1'b0;
		end else begin
			// Address and data taken together, never while a response waits
			awReadyQ <= busReq.awValid && busReq.wValid && !awReadyQ && !bValidQ;
			if (writeFire)
				bValidQ <= 1'b1;
			else if (bValidQ && busReq.bReady)
				bValidQ <= 1'b0;  // Response taken

			arReadyQ <= busReq.arValid && !arReadyQ && !rValidQ;
			if (readFire)
				rValidQ <= 1'b1;
			else if (rValidQ && busReq.rReady)
				rValidQ <= 1'b0;

			trigger <= writeFire && (busReq.awAddr == AddrNr34) && busReq.wData[7];
		end
	end

	always_ff @(posedge iClock) begin
		if (readFire)
			rDataQ <= readMux;   // Held stable while rValid waits
	end

	assign busRsp = '{
		awReady: awReadyQ,
		wReady:  awReadyQ,       // Same cycle as awReady
		bValid:  bValidQ,
		arReady: arReadyQ,
		rValid:  rValidQ,
		rData:   rDataQ
	};

	////////////////////////////////////////////////////////////
	// Registers and wave RAM
	////////////////////////////////////////////////////////////
	assign writeWave = (busReq.awAddr[7:4] == AddrWaveBase[7:4]);
	assign readWave  = (busReq.arAddr[7:4] == AddrWaveBase[7:4]);

	always_ff @(posedge iClock) begin
		if (reset) begin
			nr30 <= '0;
			nr31 <= '0;
			nr32 <= '0;
			nr33 <= '0;
			nr34 <= '0;
			for (int i = 0; i < WaveRamBytes; i++)
				waveRam[i] <= '0;
		end else if (writeFire) begin
			if (writeWave)
				waveRam[busReq.awAddr[3:0]] <= busReq.wData[7:0];  // Lane 7:0 only
			else begin
				case (busReq.awAddr)
					AddrNr30: nr30 <= busReq.wData[7:0];
					AddrNr31: nr31 <= busReq.wData[7:0];
					AddrNr32: nr32 <= busReq.wData[7:0];
					AddrNr33: nr33 <= busReq.wData[7:0];
					AddrNr34: nr34 <= busReq.wData[6:0];  // Bit 7 only fires trigger
					default:  ;                           // Status and holes ignore writes
				endcase
			end
		end
	end

	// Read data mux, unmapped addresses give 0
	always_comb begin
		readMux = '0;
		if (readWave)
			readMux[7:0] = waveRam[busReq.arAddr[3:0]];
		else begin
			case (busReq.arAddr)
				AddrNr30:   readMux[7:0] = nr30;
				AddrNr31:   readMux[7:0] = nr31;
				AddrNr32:   readMux[7:0] = nr32;
				AddrNr33:   readMux[7:0] = nr33;
				AddrNr34:   readMux[7:0] = {1'b0, nr34};  // Trigger reads as 0
				AddrStatus: readMux[0]   = channelOn;
				default:    readMux      = '0;
			endcase
		end
	end

	// Channel side
	assign waveByte = waveRam[waveAddr];  // Combinational sample fetch
	assign cfg = '{
		dacOn:        nr30[7],
		lengthLoad:   nr31,
		level:        nr32[6:5],
		freq:         {nr34[2:0], nr33},
		lengthEnable: nr34[6]
	};

endmodule

`default_nettype wire

// File: source/apuTickGen.sv
`timescale 1ns/1ps
`default_nettype none

module apuTickGen import apuWavePkg::*; (
	input  wire  iClock,
	input  wire  reset,
	output logic lengthTick,  // 256 Hz, one cycle wide
	output logic waveTick     // Wave timer enable
);

	logic [LengthCntW-1:0] lengthCnt;
	logic [WaveCntW-1:0]   waveCnt;
	logic                  lengthWrap;
	logic                  waveWrap;

	// Last count of each divider
	assign lengthWrap = (lengthCnt == LengthCntW'(LengthTickDiv - 1));
	assign waveWrap   = (waveCnt == WaveCntW'(WaveTickDiv - 1));

	// Frame tick divider
	always_ff @(posedge iClock) begin
		if (reset) begin
			lengthCnt  <= '0;
			lengthTick <= 1'b0;
		end else begin
			lengthCnt  <= lengthWrap ? '0 : lengthCnt + 1'b1;
			lengthTick <= lengthWrap;  // Registered, one cycle per wrap
		end
	end

	// Wave timer divider
	always_ff @(posedge iClock) begin
		if (reset) begin
			waveCnt  <= '0;
			waveTick <= 1'b0;
		end else begin
			waveCnt  <= waveWrap ? '0 : waveCnt + 1'b1;
			waveTick <= waveWrap;      // First pulse 2 cycles out of reset
		end
	end

endmodule

`default_nettype wire

// File: source/apuWavePkg.sv
`default_nettype none

package apuWavePkg;

	typedef logic [3:0]  sampleT;   // One wave nibble or DAC code
	typedef logic [1:0]  levelT;    // 0 mute, 1 full, 2 half, 3 quarter
	typedef logic [10:0] freqT;
	typedef logic [11:0] periodT;   // 2048 - freq, needs one more bit
	typedef logic [8:0]  lengthT;   // 256 - NR31, up to 256
	typedef logic [4:0]  wavePosT;  // Nibble index 0..31

	////////////////////////////////////////////////////////////
	// Fixed dividers from the 4194304 Hz system clock
	////////////////////////////////////////////////////////////
	localparam int LengthTickDiv = 16384;  // 256 Hz frame tick
	localparam int WaveTickDiv   = 2;      // 2 MHz wave timer tick
	localparam int LengthCntW    = $clog2(LengthTickDiv);
	localparam int WaveCntW      = $clog2(WaveTickDiv);

	localparam int WaveRamBytes   = 16;
	localparam int FreqPeriodBase = 2048;  // Timer period is base minus freq
	localparam int LengthBase     = 256;   // Length count is base minus NR31

	typedef enum logic {
		ChanOff,
		ChanPlaying
	} chanState;

endpackage

`default_nettype wire

// File: source/apuRegPkg.sv
`default_nettype none

package apuRegPkg;

	typedef logic [7:0]  axiAddr;     // Byte address on the register bus
	typedef logic [31:0] axiData;     // Bus data, only lane 7:0 is used
	typedef logic [7:0]  regByte;     // One NR register or one wave RAM byte
	typedef logic [1:0]  levelField;  // NR32 output level
	typedef logic [10:0] freqField;   // NR34[2:0] and NR33

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////
	localparam axiAddr AddrNr30     = 8'h00;  // DAC power
	localparam axiAddr AddrNr31     = 8'h04;  // Length load
	localparam axiAddr AddrNr32     = 8'h08;  // Output level
	localparam axiAddr AddrNr33     = 8'h0C;  // Frequency low byte
	localparam axiAddr AddrNr34     = 8'h10;  // Trigger, length enable, freq high
	localparam axiAddr AddrStatus   = 8'h14;  // Bit 0 is channel on
	localparam axiAddr AddrWaveBase = 8'h40;  // 16 bytes of samples

	// Master side of the AXI4-Lite bus
	typedef struct packed {
		logic   awValid;
		axiAddr awAddr;
		logic   wValid;
		axiData wData;
		logic   bReady;
		logic   arValid;
		axiAddr arAddr;
		logic   rReady;
	} axiReq;

	// Slave side, responses are always OKAY
	typedef struct packed {
		logic   awReady;
		logic   wReady;
		logic   bValid;
		logic   arReady;
		logic   rValid;
		axiData rData;
	} axiRsp;

	typedef struct packed {
		logic      dacOn;         // NR30[7]
		regByte    lengthLoad;    // NR31
		levelField level;         // NR32[6:5]
		freqField  freq;          // {NR34[2:0], NR33}
		logic      lengthEnable;  // NR34[6]
	} chanCfg;

endpackage

`default_nettype wire
